// ==== Makefile ====
TOOL       := verilator
TOP        := tb_dual_adc
RTL_TOP    := dual_adc_top
FLIST      := flist.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)

sim:
	rm -f $(LOG)
	$(TOOL) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== flist.f ====
src/adc_pkg.sv
src/spi_byte_if.sv
src/spi_host_xcvr.sv
src/adc_channel_reader.sv
src/sample_pair_builder.sv
src/dual_adc_top.sv
verif/tb_clkgen.sv
verif/spi_adc_model.sv
verif/tb_dual_adc.sv

// ==== src/adc_channel_reader.sv ====
`timescale 1ns/10ps

module adc_channel_reader (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         start,
	input  logic [adc_pkg::CHAN_W-1:0]   chan,
	output logic                         cs_n,
	spi_byte_if.requester                xfer,
	input  logic                         sample_ready,
	output logic                         sample_valid,
	output logic [adc_pkg::SAMPLE_W-1:0] sample
);
	import adc_pkg::*;

	reader_state_t         state;
	// Upper sample bits from the second byte
	logic [SAMPLE_W-9:0]   sample_hi;

	//////////////////////////////////////////////////
	// Frame sequencer

	always_ff @(posedge clk) begin
		if (rst) begin
			state         <= RD_IDLE;
			cs_n          <= 1'b1;
			xfer.shift_en <= 1'b0;
			sample_valid  <= 1'b0;
		end else begin
			// Strobes default low
			xfer.shift_en <= 1'b0;
			sample_valid  <= 1'b0;

			case (state)
				RD_IDLE: begin
					// Only start while the builder slot is free
					if (start && sample_ready) begin
						state         <= RD_CMD;
						cs_n          <= 1'b0;
						xfer.tx_data  <= {CMD_START, chan};
						xfer.shift_en <= 1'b1;
					end
				end

				RD_CMD: begin
					// Command out, clock the first dummy byte
					if (xfer.shift_done) begin
						state         <= RD_HI;
						xfer.tx_data  <= 8'h00;
						xfer.shift_en <= 1'b1;
					end
				end

				RD_HI: begin
					// Low nibble carries bits 11 to 8
					if (xfer.shift_done) begin
						state         <= RD_LO;
						sample_hi     <= xfer.rx_data[SAMPLE_W-9:0];
						xfer.tx_data  <= 8'h00;
						xfer.shift_en <= 1'b1;
					end
				end

				RD_LO: begin
					// Whole byte is bits 7 to 0, frame ends here
					if (xfer.shift_done) begin
						state        <= RD_GAP;
						cs_n         <= 1'b1;
						sample       <= {sample_hi, xfer.rx_data};
						sample_valid <= 1'b1;
					end
				end

				RD_GAP: begin
					// One cycle of CS high between frames
					state <= RD_IDLE;
				end

				default: begin
					state <= RD_IDLE;
					cs_n  <= 1'b1;
				end
			endcase
		end
	end

endmodule

// ==== src/adc_pkg.sv ====
package adc_pkg;

	//////////////////////////////////////////////////
	// Link and datapath widths

	// SCK divider value
	localparam int CLKDIV_W = 16;
	// ADC input mux select
	localparam int CHAN_W = 3;
	// One ADC conversion
	localparam int SAMPLE_W = 12;
	// Pair sequence tag
	localparam int SEQ_W = 8;
	// Word handed to the consumer
	localparam int PAIR_W = 32;

	//////////////////////////////////////////////////
	// Flow control

	// Credits granted by the consumer at reset
	localparam int CREDIT_W = 3;
	localparam logic [CREDIT_W-1:0] CREDIT_MAX = 3'd4;

	//////////////////////////////////////////////////
	// ADC command frame

	// Command byte is this prefix then the channel select
	localparam logic [4:0] CMD_START = 5'b11000;

	// Reader sequencer states
	typedef enum logic [2:0] {
		RD_IDLE,
		RD_CMD,
		RD_HI,
		RD_LO,
		RD_GAP
	} reader_state_t;

	// Output word, tag in the top byte, channel A above channel B
	typedef struct packed {
		logic [SEQ_W-1:0]    tag;
		logic [SAMPLE_W-1:0] a_sample;
		logic [SAMPLE_W-1:0] b_sample;
	} pair_word_t;

endpackage

// ==== src/dual_adc_top.sv ====
`timescale 1ns/10ps

module dual_adc_top (
	input  logic                         clk,
	input  logic                         rst,
	input  logic [adc_pkg::CLKDIV_W-1:0] clkdiv,
	input  logic                         trigger,
	input  logic [adc_pkg::CHAN_W-1:0]   chan_a,
	input  logic [adc_pkg::CHAN_W-1:0]   chan_b,
	output logic                         sck_a,
	output logic                         mosi_a,
	output logic                         cs_n_a,
	input  logic                         miso_a,
	output logic                         sck_b,
	output logic                         mosi_b,
	output logic                         cs_n_b,
	input  logic                         miso_b,
	output logic                         busy,
	output logic                         out_valid,
	output logic [adc_pkg::PAIR_W-1:0]   out_data,
	input  logic                         credit_return
);
	import adc_pkg::*;

	// Common start to both readers
	logic                start;
	logic                a_valid;
	logic                b_valid;
	logic                a_ready;
	logic                b_ready;
	logic [SAMPLE_W-1:0] a_sample;
	logic [SAMPLE_W-1:0] b_sample;

	// Byte links, one per channel
	spi_byte_if xfer_a ();
	spi_byte_if xfer_b ();

	//////////////////////////////////////////////////
	// Channel A

	adc_channel_reader reader_a (
		.clk(clk), .rst(rst), .start(start), .chan(chan_a), .cs_n(cs_n_a),
		.xfer(xfer_a.requester), .sample_ready(a_ready),
		.sample_valid(a_valid), .sample(a_sample)
	);

	spi_host_xcvr xcvr_a (
		.clk(clk), .rst(rst), .clkdiv(clkdiv),
		.sck(sck_a), .mosi(mosi_a), .miso(miso_a), .bus(xfer_a.shifter)
	);

	//////////////////////////////////////////////////
	// Channel B

	adc_channel_reader reader_b (
		.clk(clk), .rst(rst), .start(start), .chan(chan_b), .cs_n(cs_n_b),
		.xfer(xfer_b.requester), .sample_ready(b_ready),
		.sample_valid(b_valid), .sample(b_sample)
	);

	spi_host_xcvr xcvr_b (
		.clk(clk), .rst(rst), .clkdiv(clkdiv),
		.sck(sck_b), .mosi(mosi_b), .miso(miso_b), .bus(xfer_b.shifter)
	);

	// Pairing, tagging and credit release
	sample_pair_builder builder (
		.clk(clk), .rst(rst),
		.a_valid(a_valid), .b_valid(b_valid),
		.a_sample(a_sample), .b_sample(b_sample),
		.a_ready(a_ready), .b_ready(b_ready),
		.trigger(trigger), .start(start), .busy(busy),
		.credit_return(credit_return),
		.out_valid(out_valid), .out_data(out_data)
	);

endmodule

// ==== src/sample_pair_builder.sv ====
`timescale 1ns/10ps

module sample_pair_builder (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         a_valid,
	input  logic                         b_valid,
	input  logic [adc_pkg::SAMPLE_W-1:0] a_sample,
	input  logic [adc_pkg::SAMPLE_W-1:0] b_sample,
	output logic                         a_ready,
	output logic                         b_ready,
	input  logic                         trigger,
	output logic                         start,
	output logic                         busy,
	input  logic                         credit_return,
	output logic                         out_valid,
	output logic [adc_pkg::PAIR_W-1:0]   out_data
);
	import adc_pkg::*;

	// Slot flags and contents
	logic                a_full;
	logic                b_full;
	logic [SAMPLE_W-1:0] a_slot;
	logic [SAMPLE_W-1:0] b_slot;

	logic [SEQ_W-1:0]    seq;
	logic [CREDIT_W-1:0] credits;
	logic                accept;
	logic                send;
	pair_word_t          next_word;

	// A slot takes a sample while empty
	assign a_ready = !a_full;
	assign b_ready = !b_full;

	// New pair only from idle with nothing left over
	assign accept = trigger && !busy && !a_full && !b_full;
	// Both halves in and the consumer has room
	assign send = a_full && b_full && (credits != '0);

	assign next_word = '{tag: seq, a_sample: a_slot, b_sample: b_slot};

	//////////////////////////////////////////////////
	// Slots, trigger and release

	always_ff @(posedge clk) begin
		if (rst) begin
			a_full    <= 1'b0;
			b_full    <= 1'b0;
			busy      <= 1'b0;
			start     <= 1'b0;
			out_valid <= 1'b0;
			seq       <= '0;
		end else begin
			start     <= accept;
			out_valid <= send;

			if (accept) begin
				busy <= 1'b1;
			end

			// Readers only run after a start, so no overrun here
			if (a_valid) begin
				a_full <= 1'b1;
				a_slot <= a_sample;
			end
			if (b_valid) begin
				b_full <= 1'b1;
				b_slot <= b_sample;
			end

			if (send) begin
				out_data <= next_word;
				a_full   <= 1'b0;
				b_full   <= 1'b0;
				busy     <= 1'b0;
				// Wraps at 255
				seq      <= seq + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Credit counter

	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= CREDIT_MAX;
		end else begin
			case ({send, credit_return})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				// Send and return together cancel out
				default: credits <= credits;
			endcase
		end
	end

endmodule

// ==== src/spi_byte_if.sv ====
`timescale 1ns/10ps

interface spi_byte_if;

	// Start one byte transfer, single cycle
	logic       shift_en;
	// Byte to put on MOSI
	logic [7:0] tx_data;
	// End of transfer, single cycle
	logic       shift_done;
	// Byte collected from MISO, held until the next start
	logic [7:0] rx_data;

	// Sequencer side
	modport requester (
		output shift_en,
		output tx_data,
		input  shift_done,
		input  rx_data
	);

	// Bit engine side
	modport shifter (
		input  shift_en,
		input  tx_data,
		output shift_done,
		output rx_data
	);

endinterface

// ==== src/spi_host_xcvr.sv ====
`timescale 1ns/10ps

module spi_host_xcvr (
	input  logic                         clk,
	input  logic                         rst,
	input  logic [adc_pkg::CLKDIV_W-1:0] clkdiv,
	output logic                         sck,
	output logic                         mosi,
	input  logic                         miso,
	spi_byte_if.shifter                  bus
);
	import adc_pkg::*;

	//////////////////////////////////////////////////
	// Half period timing

	// Transfer in flight
	logic                active;
	// Last falling edge seen, one trailing half period left
	logic                almost_done;
	// Count limit for one SCK half period
	logic [CLKDIV_W-1:0] half_lim;
	logic [CLKDIV_W-1:0] clkcount;
	logic                half_tick;

	//////////////////////////////////////////////////
	// Shift registers

	// Falling edges done so far
	logic [2:0]          bit_cnt;
	// Bits still to go out after the MSB
	logic [6:0]          tx_shreg;
	logic [7:0]          rx_shreg;

	// Half period is clkdiv/2 + 1 clocks
	assign half_lim  = clkdiv >> 1;
	assign half_tick = (clkcount >= half_lim);

	// Receive register goes straight out, stable once the last bit is in
	assign bus.rx_data = rx_shreg;

	always_ff @(posedge clk) begin
		if (rst) begin
			active         <= 1'b0;
			almost_done    <= 1'b0;
			sck            <= 1'b0;
			mosi           <= 1'b0;
			clkcount       <= '0;
			bus.shift_done <= 1'b0;
		end else begin
			bus.shift_done <= 1'b0;

			if (bus.shift_en) begin
				// Load the byte, MSB goes onto MOSI right away
				active      <= 1'b1;
				almost_done <= 1'b0;
				clkcount    <= '0;
				bit_cnt     <= '0;
				sck         <= 1'b0;
				mosi        <= bus.tx_data[7];
				tx_shreg    <= bus.tx_data[6:0];
			end else if (active) begin
				if (half_tick) begin
					clkcount <= '0;

					if (almost_done) begin
						// Trailing half period over with SCK low
						active         <= 1'b0;
						almost_done    <= 1'b0;
						bus.shift_done <= 1'b1;
					end else if (!sck) begin
						// Rising edge, both ends sample here in mode 0
						sck      <= 1'b1;
						rx_shreg <= {rx_shreg[6:0], miso};
					end else begin
						// Falling edge
						sck     <= 1'b0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							almost_done <= 1'b1;
						end else begin
							// Next bit out
							mosi     <= tx_shreg[6];
							tx_shreg <= {tx_shreg[5:0], 1'b0};
						end
					end
				end else begin
					clkcount <= clkcount + 1'b1;
				end
			end
		end
	end

endmodule

// ==== verif/spi_adc_model.sv ====
`timescale 1ns/10ps

module spi_adc_model (
	input  logic sck,
	input  logic cs_n,
	input  logic mosi,
	output logic miso
);
	import adc_pkg::*;

	// Conversion result per input channel, filled by the testbench
	logic [SAMPLE_W-1:0] table_mem [8];

	logic [7:0]          cmd = '0;
	// Reply shifted out MSB first, four zero bits then the sample
	logic [15:0]         resp = '0;
	int                  bit_cnt = 0;

	//////////////////////////////////////////////////
	// Mode 0 slave, sample on rise, shift on fall

	always @(posedge sck or negedge sck or posedge cs_n) begin
		if (cs_n) begin
			// Frame over
			bit_cnt <= 0;
			resp    <= '0;
		end else if (sck) begin
			cmd     <= {cmd[6:0], mosi};
			bit_cnt <= bit_cnt + 1;
		end else if (bit_cnt == 8) begin
			// Command byte complete, reply starts on this falling edge
			resp <= (cmd[7:3] == 5'b11000) ? {4'h0, table_mem[cmd[2:0]]} : 16'h0000;
		end else begin
			resp <= resp << 1;
		end
	end

	assign miso = resp[15];

endmodule

// ==== verif/tb_clkgen.sv ====
`timescale 1ns/10ps

module tb_clkgen (
	output logic clk,
	output logic rst
);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Reset held for five rising edges, released on an edge
	initial begin
		rst = 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// ==== verif/tb_dual_adc.sv ====
`timescale 1ns/10ps

module tb_dual_adc;
	import adc_pkg::*;

	// Bound for every wait, in clock cycles
	localparam int WAIT_MAX = 5000;

	logic                clk;
	logic                rst;
	logic [CLKDIV_W-1:0] clkdiv;
	logic                trigger;
	logic [CHAN_W-1:0]   chan_a;
	logic [CHAN_W-1:0]   chan_b;
	logic                credit_return = 1'b0;
	logic                sck_a;
	logic                mosi_a;
	logic                cs_n_a;
	logic                miso_a;
	logic                sck_b;
	logic                mosi_b;
	logic                cs_n_b;
	logic                miso_b;
	logic                busy;
	logic                out_valid;
	logic [PAIR_W-1:0]   out_data;

	// Expected channel fields in trigger order
	logic [23:0]         exp_q[$];
	// Words taken by the consumer
	logic [PAIR_W-1:0]   rx_q[$];
	logic [23:0]         exp_head = '0;
	int                  exp_cnt = 0;
	logic [SEQ_W-1:0]    exp_tag = '0;
	// Words held by the consumer and not yet freed
	int                  outstanding = 0;
	int                  accepted = 0;
	logic                hold_credits = 1'b0;
	int                  ret_delay = 0;
	int                  ret_wait = 0;
	logic                was_rst = 1'b0;
	int                  data_err = 0;
	int                  tag_err = 0;
	int                  proto_err = 0;
	int                  wait_err = 0;

	tb_clkgen clkgen (.clk(clk), .rst(rst));

	dual_adc_top dual_adc_top_i (.*);

	spi_adc_model adc_a (.sck(sck_a), .cs_n(cs_n_a), .mosi(mosi_a), .miso(miso_a));
	spi_adc_model adc_b (.sck(sck_b), .cs_n(cs_n_b), .mosi(mosi_b), .miso(miso_b));

	//////////////////////////////////////////////////
	// Reference model and consumer

	always @(posedge clk) begin
		was_rst <= rst;
		if (rst) begin
			credit_return <= 1'b0;
			outstanding   <= 0;
			ret_wait      <= 0;
			exp_tag       <= '0;
		end else begin
			// Trigger counts only while the DUT is idle
			if (trigger && !busy) begin
				exp_q.push_back({adc_a.table_mem[chan_a], adc_b.table_mem[chan_b]});
				accepted <= accepted + 1;
			end
			if (out_valid) begin
				rx_q.push_back(out_data);
				if (exp_q.size() > 0) begin
					void'(exp_q.pop_front());
				end
				exp_tag <= exp_tag + 1'b1;
			end
			exp_cnt  <= exp_q.size();
			exp_head <= (exp_q.size() > 0) ? exp_q[0] : '0;
			outstanding <= outstanding + int'(out_valid) - int'(credit_return);
			// One credit back per freed word, after ret_delay idle cycles
			credit_return <= 1'b0;
			if (!hold_credits && (outstanding + int'(out_valid) - int'(credit_return)) > 0) begin
				if (ret_wait >= ret_delay) begin
					credit_return <= 1'b1;
					ret_wait      <= 0;
				end else begin
					ret_wait <= ret_wait + 1;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Checks

	data_check: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> out_data[23:0] == exp_head)
		else begin
			data_err = data_err + 1;
			$display("** Error at %0t: out_data[23:0] = %h, expected %h",
				$time, $sampled(out_data[23:0]), $sampled(exp_head));
		end

	tag_check: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> out_data[31:24] == exp_tag)
		else begin
			tag_err = tag_err + 1;
			$display("** Error at %0t: out_data[31:24] = %0d, expected %0d",
				$time, $sampled(out_data[31:24]), $sampled(exp_tag));
		end

	// No word without an accepted trigger behind it
	extra_word_check: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> exp_cnt > 0)
		else begin
			proto_err = proto_err + 1;
			$display("** Error at %0t: out_valid = 1, expected 0", $time);
		end

	credit_check: assert property (@(posedge clk) disable iff (rst)
		outstanding <= int'(CREDIT_MAX))
		else begin
			proto_err = proto_err + 1;
			$display("** Error at %0t: outstanding = %0d, expected at most %0d",
				$time, $sampled(outstanding), CREDIT_MAX);
		end

	// Both links parked while idle
	idle_check: assert property (@(posedge clk) disable iff (rst)
		!busy |-> {cs_n_a, cs_n_b, sck_a, sck_b} == 4'b1100)
		else begin
			proto_err = proto_err + 1;
			$display("** Error at %0t: {cs_n_a, cs_n_b, sck_a, sck_b} = %b, expected 1100",
				$time, $sampled({cs_n_a, cs_n_b, sck_a, sck_b}));
		end

	sck_check: assert property (@(posedge clk) disable iff (rst)
		(sck_a == $past(sck_a) || !cs_n_a) && (sck_b == $past(sck_b) || !cs_n_b))
		else begin
			proto_err = proto_err + 1;
			$display("SCK moved on a channel with chip select high at %0t", $time);
		end

	reset_check: assert property (@(posedge clk)
		was_rst |-> {cs_n_a, cs_n_b, sck_a, sck_b, out_valid, busy} == 6'b110000)
		else begin
			proto_err = proto_err + 1;
			$display({"** Error at %0t: {cs_n_a, cs_n_b, sck_a, sck_b, out_valid, busy}",
				" = %b, expected 110000"},
				$time, $sampled({cs_n_a, cs_n_b, sck_a, sck_b, out_valid, busy}));
		end

	//////////////////////////////////////////////////
	// Stimulus

	task automatic pulse_trigger(input logic [CHAN_W-1:0] ca, input logic [CHAN_W-1:0] cb);
		@(posedge clk);
		chan_a  <= ca;
		chan_b  <= cb;
		trigger <= 1'b1;
		@(posedge clk);
		trigger <= 1'b0;
	endtask

	// Every accepted pair delivered, DUT idle, all credits back
	task automatic wait_settled();
		int cnt;
		cnt = 0;
		do begin
			@(posedge clk);
			cnt++;
		end while ((rx_q.size() != accepted || busy || outstanding != 0) && cnt < WAIT_MAX);
		if (cnt >= WAIT_MAX) begin
			wait_err++;
			$display("Timed out at %0t with %0d of %0d words received",
				$time, rx_q.size(), accepted);
		end
	endtask

	task automatic run_pair(input logic [CLKDIV_W-1:0] div);
		@(posedge clk);
		clkdiv    <= div;
		ret_delay <= $urandom_range(0, 6);
		pulse_trigger(CHAN_W'($urandom_range(0, 7)), CHAN_W'($urandom_range(0, 7)));
		wait_settled();
	endtask

	initial begin
		int cnt;
		logic [CLKDIV_W-1:0] divs [3];
		divs    = '{16'd2, 16'd5, 16'd16};
		trigger = 1'b0;
		clkdiv  = 16'd2;
		chan_a  = '0;
		chan_b  = '0;
		void'($urandom(26));
		for (int i = 0; i < 8; i++) begin
			adc_a.table_mem[i] = SAMPLE_W'($urandom);
			adc_b.table_mem[i] = SAMPLE_W'($urandom);
		end

		cnt = 0;
		do begin
			@(posedge clk);
			cnt++;
		end while (rst && cnt < 100);
		if (rst) begin
			wait_err++;
			$display("Reset never released");
		end

		// Single pairs over three SCK rates
		foreach (divs[d]) begin
			repeat (3) run_pair(divs[d]);
		end

		// Credits withheld, the sixth trigger meets a stalled DUT
		@(posedge clk);
		clkdiv       <= 16'd2;
		hold_credits <= 1'b1;
		repeat (6) begin
			pulse_trigger(CHAN_W'($urandom_range(0, 7)), CHAN_W'($urandom_range(0, 7)));
			repeat (150) @(posedge clk);
		end
		hold_credits <= 1'b0;
		wait_settled();

		// Extra triggers inside one busy window
		@(posedge clk);
		clkdiv <= 16'd5;
		pulse_trigger(CHAN_W'($urandom_range(0, 7)), CHAN_W'($urandom_range(0, 7)));
		repeat (3) begin
			repeat ($urandom_range(5, 30)) @(posedge clk);
			pulse_trigger(CHAN_W'($urandom_range(0, 7)), CHAN_W'($urandom_range(0, 7)));
		end
		wait_settled();

		// Let the last checks settle
		repeat (4) @(posedge clk);
		if (rx_q.size() != accepted) begin
			proto_err++;
			$display("Got %0d words for %0d accepted triggers", rx_q.size(), accepted);
		end
		$display("Errors: data %0d, tag %0d, protocol %0d, timeout %0d",
			data_err, tag_err, proto_err, wait_err);
		if (data_err + tag_err + proto_err + wait_err == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule
